/* vlog.f */
+incdir+src
src/isa_pkg.sv
src/exec_pkg.sv
src/dec_exe_if.sv
src/instr_decoder.sv
src/seq_multiplier.sv
src/exec_unit.sv
src/exec_stage_top.sv
tests/tb_exec_stage.sv

/* run_sim.sh */
#!/bin/sh
# build and run the execute stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
    --top-module tb_exec_stage -o tb_exec_stage > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_exec_stage > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TB FAILED" sim.log; then
    exit 1
fi
exit 0

/* tests/tb_exec_stage.sv */
`timescale 1ns/1ps
`include "core_defs.svh"
`default_nettype none

module tb_exec_stage;
    localparam int CLK_PERIOD   = 20;
    localparam int DRIVE_DELAY  = 2;
    localparam int RESET_CYCLES = 4;
    localparam int ROW_CYCLES   = 40;            // watchdog budget per row
    localparam int MUL_STALL    = `MUL_ITERS + 1;
    localparam int MUL_VECTORS  = 8;
    localparam logic [31:0] SEED = 32'hd95e;
    localparam logic [`WORD_W-1:0] PC_A = 32'h4000_1000;

    typedef struct packed {
        logic [`WORD_W-1:0] instr;
        logic [`WORD_W-1:0] reg1;
        logic [`WORD_W-1:0] reg2;
        logic [`WORD_W-1:0] next_pc;
        logic [`WORD_W-1:0] exp_result;
        logic               exp_jump;
        logic [`WORD_W-1:0] exp_addr;
        logic               is_mul;      // wait for stall to drop
    } row_t;

    logic               sys_clk;
    logic               rst_n;
    logic [`WORD_W-1:0] instr;
    logic [`WORD_W-1:0] reg1;
    logic [`WORD_W-1:0] reg2;
    logic [`WORD_W-1:0] next_pc;
    wire  [`WORD_W-1:0] result;
    wire                do_jump;
    wire  [`WORD_W-1:0] j_addr;
    wire                stall;

    row_t rows[$];
    int   n_rows = 0;
    int   value_errs = 0;
    int   stall_errs = 0;

    exec_stage_top uut (
        .sys_clk (sys_clk),
        .rst_n   (rst_n),
        .instr   (instr),
        .reg1    (reg1),
        .reg2    (reg2),
        .next_pc (next_pc),
        .result  (result),
        .do_jump (do_jump),
        .j_addr  (j_addr),
        .stall   (stall)
    );

    initial begin
        sys_clk = 1'b0;
        forever #(CLK_PERIOD / 2) sys_clk = ~sys_clk;
    end

    // register fields are don't care, operands come in on reg1/reg2
    function automatic logic [31:0] r_word(input logic [5:0] fn, input logic [4:0] sh);
        return {6'b000000, 5'd1, 5'd2, 5'd3, sh, fn};
    endfunction

    function automatic logic [31:0] imm_word(input logic [5:0] op, input logic [15:0] imm);
        return {op, 5'd1, 5'd2, imm};
    endfunction

    function automatic logic [31:0] jump_word(input logic [5:0] op, input logic [25:0] idx);
        return {op, idx};
    endfunction

    task automatic add_row(input logic [`WORD_W-1:0] ins, input logic [`WORD_W-1:0] r1,
                           input logic [`WORD_W-1:0] r2, input logic [`WORD_W-1:0] res,
                           input logic [`WORD_W-1:0] pc = '0, input logic jmp = 1'b0,
                           input logic [`WORD_W-1:0] addr = '0, input logic mul = 1'b0);
        row_t r;
        r = '{instr: ins, reg1: r1, reg2: r2, next_pc: pc, exp_result: res,
              exp_jump: jmp, exp_addr: addr, is_mul: mul};
        rows.push_back(r);
    endtask

    task automatic add_mul_rows();
        logic [`WORD_W-1:0]   a;
        logic [`WORD_W-1:0]   b;
        logic [2*`WORD_W-1:0] prod;
        logic                 sgn;
        logic                 high;
        for (int k = 0; k < MUL_VECTORS; k++) begin
            a    = $urandom();
            b    = $urandom();
            sgn  = k[0];
            high = k[1];
            if (sgn)
                prod = $signed({{`WORD_W{a[31]}}, a}) * $signed({{`WORD_W{b[31]}}, b});
            else
                prod = {{`WORD_W{1'b0}}, a} * {{`WORD_W{1'b0}}, b};
            add_row(r_word(sgn ? isa_pkg::FN_MULT : isa_pkg::FN_MULTU, high ? 5'd3 : 5'd2),
                    a, b, high ? prod[63:32] : prod[31:0], '0, 1'b0, '0, 1'b1);
        end
    endtask

    task automatic build_table();
        // arithmetic, logic, immediates, address calc
        add_row(r_word(isa_pkg::FN_ADD, 5'd0), 32'h1234_5678, 32'h0fed_cba9, 32'h2222_2221);
        add_row(r_word(isa_pkg::FN_ADDU, 5'd0), 32'hffff_ffff, 32'h0000_0002, 32'h0000_0001);
        add_row(r_word(isa_pkg::FN_SUB, 5'd0), 32'd5, 32'd7, 32'hffff_fffe);
        add_row(r_word(isa_pkg::FN_SUBU, 5'd0), 32'h8000_0000, 32'd1, 32'h7fff_ffff);
        add_row(r_word(isa_pkg::FN_AND, 5'd0), 32'hf0f0_1234, 32'h0ff0_5678, 32'h00f0_1230);
        add_row(r_word(isa_pkg::FN_OR, 5'd0), 32'hf0f0_1234, 32'h0ff0_5678, 32'hfff0_567c);
        add_row(r_word(isa_pkg::FN_XOR, 5'd0), 32'hf0f0_1234, 32'h0ff0_5678, 32'hff00_444c);
        add_row(r_word(isa_pkg::FN_NOR, 5'd0), 32'hf0f0_1234, 32'h0ff0_5678, 32'h000f_a983);
        add_row(imm_word(isa_pkg::OP_ADDI, 16'hfff6), 32'd100, 32'd0, 32'h0000_005a);
        add_row(imm_word(isa_pkg::OP_ADDIU, 16'h0020), 32'hffff_fff0, 32'd0, 32'h0000_0010);
        add_row(imm_word(isa_pkg::OP_ANDI, 16'h8001), 32'hffff_ffff, 32'd0, 32'h0000_8001);
        add_row(imm_word(isa_pkg::OP_ORI, 16'habcd), 32'h1234_0000, 32'd0, 32'h1234_abcd);
        add_row(imm_word(isa_pkg::OP_XORI, 16'h8f0f), 32'h0000_ffff, 32'd0, 32'h0000_70f0);
        add_row(imm_word(isa_pkg::OP_LUI, 16'hbeef), 32'h1111_1111, 32'd0, 32'hbeef_0000);
        add_row(imm_word(isa_pkg::OP_LW, 16'hfffc), 32'h1000_0000, 32'd0, 32'h0fff_fffc);
        add_row(imm_word(isa_pkg::OP_SW, 16'h0008), 32'h2000_0010, 32'd0, 32'h2000_0018);
        // -2 against 3, signed and unsigned order differ
        add_row(r_word(isa_pkg::FN_SLT, 5'd0), 32'hffff_fffe, 32'd3, 32'd1);
        add_row(r_word(isa_pkg::FN_SLTU, 5'd0), 32'hffff_fffe, 32'd3, 32'd0);
        add_row(r_word(isa_pkg::FN_SLT, 5'd0), 32'd3, 32'hffff_fffe, 32'd0);
        add_row(r_word(isa_pkg::FN_SLTU, 5'd0), 32'd3, 32'hffff_fffe, 32'd1);
        add_row(imm_word(isa_pkg::OP_SLTI, 16'h0003), 32'hffff_fffe, 32'd0, 32'd1);
        add_row(imm_word(isa_pkg::OP_SLTIU, 16'h0003), 32'hffff_fffe, 32'd0, 32'd0);
        add_row(imm_word(isa_pkg::OP_SLTI, 16'hfffe), 32'd3, 32'd0, 32'd0);
        add_row(imm_word(isa_pkg::OP_SLTIU, 16'hfffe), 32'd3, 32'd0, 32'd1);
        // shifts on a negative reg2
        add_row(r_word(isa_pkg::FN_SLL, 5'd0), 32'd0, 32'h8000_0f01, 32'h8000_0f01);
        add_row(r_word(isa_pkg::FN_SLL, 5'd1), 32'd0, 32'h8000_0f01, 32'h0000_1e02);
        add_row(r_word(isa_pkg::FN_SLL, 5'd31), 32'd0, 32'h8000_0f01, 32'h8000_0000);
        add_row(r_word(isa_pkg::FN_SRL, 5'd0), 32'd0, 32'h8000_0f01, 32'h8000_0f01);
        add_row(r_word(isa_pkg::FN_SRL, 5'd1), 32'd0, 32'h8000_0f01, 32'h4000_0780);
        add_row(r_word(isa_pkg::FN_SRL, 5'd31), 32'd0, 32'h8000_0f01, 32'h0000_0001);
        add_row(r_word(isa_pkg::FN_SRA, 5'd0), 32'd0, 32'h8000_0f01, 32'h8000_0f01);
        add_row(r_word(isa_pkg::FN_SRA, 5'd1), 32'd0, 32'h8000_0f01, 32'hc000_0780);
        add_row(r_word(isa_pkg::FN_SRA, 5'd31), 32'd0, 32'h8000_0f01, 32'hffff_ffff);
        add_row(r_word(isa_pkg::FN_SLLV, 5'd0), 32'd4, 32'h8000_0f01, 32'h0000_f010);
        add_row(r_word(isa_pkg::FN_SRLV, 5'd0), 32'd31, 32'h8000_0f01, 32'h0000_0001);
        add_row(r_word(isa_pkg::FN_SRAV, 5'd0), 32'h23, 32'h8000_0f01, 32'hf000_01e0); // low 5 bits
        add_row(r_word(isa_pkg::FN_SRAV, 5'd0), 32'd1, 32'h7000_0f00, 32'h3800_0780);
        // fixed multiplies, then random ones
        add_row(r_word(isa_pkg::FN_MULT, 5'd2), 32'hffff_fffd, 32'd7, 32'hffff_ffeb,
                '0, 1'b0, '0, 1'b1);
        add_row(r_word(isa_pkg::FN_MULT, 5'd3), 32'hffff_fffd, 32'd7, 32'hffff_ffff,
                '0, 1'b0, '0, 1'b1);
        add_row(r_word(isa_pkg::FN_MULTU, 5'd2), 32'hffff_ffff, 32'hffff_ffff, 32'h0000_0001,
                '0, 1'b0, '0, 1'b1);
        add_row(r_word(isa_pkg::FN_MULTU, 5'd3), 32'hffff_ffff, 32'hffff_ffff, 32'hffff_fffe,
                '0, 1'b0, '0, 1'b1);
        add_mul_rows();
        // branches, taken and not taken
        add_row(imm_word(isa_pkg::OP_BEQ, 16'h0010), 32'd5, 32'd5, 32'd0, PC_A, 1'b1, 32'h4000_1040);
        add_row(imm_word(isa_pkg::OP_BEQ, 16'h0010), 32'd5, 32'd6, 32'd0, PC_A);
        add_row(imm_word(isa_pkg::OP_BNE, 16'hfffc), 32'd5, 32'd6, 32'd0, PC_A, 1'b1, 32'h4000_0ff0);
        add_row(imm_word(isa_pkg::OP_BNE, 16'hfffc), 32'd6, 32'd6, 32'd0, PC_A);
        add_row(imm_word(isa_pkg::OP_BLEZ, 16'h0008), 32'd0, 32'd0, 32'd0, PC_A, 1'b1, 32'h4000_1020);
        add_row(imm_word(isa_pkg::OP_BLEZ, 16'h0100), 32'h8000_0000, 32'd0, 32'd0, PC_A, 1'b1,
                32'h4000_1400);
        add_row(imm_word(isa_pkg::OP_BLEZ, 16'h0008), 32'd1, 32'd0, 32'd0, PC_A);
        add_row(imm_word(isa_pkg::OP_BGEZ, 16'h8000), 32'd0, 32'd0, 32'd0, PC_A, 1'b1, 32'h3ffe_1000);
        add_row(imm_word(isa_pkg::OP_BGEZ, 16'h8000), 32'hffff_ffff, 32'd0, 32'd0, PC_A);
        // region jumps and register jumps
        add_row(jump_word(isa_pkg::OP_J, 26'h012_3456), 32'd0, 32'd0, 32'd0, PC_A, 1'b1,
                32'h4048_d158);
        add_row(jump_word(isa_pkg::OP_JAL, 26'h3ff_fff0), 32'd0, 32'd0, 32'h8000_0ff4,
                32'h8000_0ff0, 1'b1, 32'h8fff_ffc0);
        add_row(r_word(isa_pkg::FN_JR, 5'd0), 32'h0040_0abc, 32'd0, 32'd0, PC_A, 1'b1,
                32'h0040_0abc);
        add_row(r_word(isa_pkg::FN_JALR, 5'd0), 32'h0040_0100, 32'd0, 32'h4000_1004, PC_A, 1'b1,
                32'h0040_0100);
    endtask

    task automatic check_word(input int idx, input string name,
                              input logic [`WORD_W-1:0] got, input logic [`WORD_W-1:0] exp);
        if (got !== exp) begin
            $display("Fail row %0d %s: got 0x%h expected 0x%h", idx, name, got, exp);
            value_errs++;
        end
    endtask

    task automatic check_flag(input int idx, input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail row %0d %s: got 0x%h expected 0x%h", idx, name, got, exp);
            value_errs++;
        end
    endtask

    task automatic apply_row(input int idx);
        row_t r;
        int   stall_cycles;
        r = rows[idx];
        @(posedge sys_clk);
        #DRIVE_DELAY;
        instr   = r.instr;
        reg1    = r.reg1;
        reg2    = r.reg2;
        next_pc = r.next_pc;
        @(negedge sys_clk);                  // outputs settled mid cycle
        if (r.is_mul) begin
            stall_cycles = 0;
            while (stall === 1'b1) begin
                stall_cycles++;
                @(negedge sys_clk);
            end
            if (stall_cycles != MUL_STALL) begin
                $display("row %0d: stall was high for %0d cycles where %0d were expected",
                         idx, stall_cycles, MUL_STALL);
                stall_errs++;
            end
        end else begin
            check_flag(idx, "stall", stall, 1'b0);
        end
        check_flag(idx, "do_jump", do_jump, r.exp_jump);
        if (r.exp_jump)
            check_word(idx, "j_addr", j_addr, r.exp_addr);
        check_word(idx, "result", result, r.exp_result);
    endtask

    initial begin
        rst_n   = 1'b0;
        instr   = '0;
        reg1    = '0;
        reg2    = '0;
        next_pc = '0;
        void'($urandom(SEED));
        build_table();
        n_rows = rows.size();
        repeat (RESET_CYCLES) @(posedge sys_clk);
        #DRIVE_DELAY rst_n = 1'b1;
        foreach (rows[i])
            apply_row(i);
        $display("errors: %0d value mismatches, %0d stall length errors over %0d rows",
                 value_errs, stall_errs, n_rows);
        if (value_errs == 0 && stall_errs == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

    // watchdog, sized once the table is known
    initial begin
        wait (n_rows > 0);
        repeat (n_rows * ROW_CYCLES + RESET_CYCLES) @(posedge sys_clk);
        $display("timeout: the table did not finish within %0d cycles",
                 n_rows * ROW_CYCLES + RESET_CYCLES);
        $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* src/exec_stage_top.sv */
`timescale 1ns/1ps
`include "core_defs.svh"
`default_nettype none

module exec_stage_top (
    input  wire                 sys_clk,
    input  wire                 rst_n,
    input  wire  [`WORD_W-1:0]  instr,
    input  wire  [`WORD_W-1:0]  reg1,
    input  wire  [`WORD_W-1:0]  reg2,
    input  wire  [`WORD_W-1:0]  next_pc,
    output wire  [`WORD_W-1:0]  result,
    output wire                 do_jump,
    output wire  [`WORD_W-1:0]  j_addr,
    output wire                 stall       // multiply in progress
);

    dec_exe_if dec_bus ();

    instr_decoder u_dec (
        .instr (instr),
        .dec   (dec_bus.dec)
    );

    exec_unit u_exe (
        .sys_clk (sys_clk),
        .rst_n   (rst_n),
        .reg1    (reg1),
        .reg2    (reg2),
        .next_pc (next_pc),
        .exe     (dec_bus.exe),
        .result  (result),
        .do_jump (do_jump),
        .j_addr  (j_addr),
        .stall   (stall)
    );

endmodule

`default_nettype wire

/* src/exec_unit.sv */
`timescale 1ns/1ps
`include "core_defs.svh"
`default_nettype none

module exec_unit (
    input  wire                 sys_clk,
    input  wire                 rst_n,
    input  wire  [`WORD_W-1:0]  reg1,       // rs
    input  wire  [`WORD_W-1:0]  reg2,       // rt
    input  wire  [`WORD_W-1:0]  next_pc,
    dec_exe_if.exe              exe,
    output logic [`WORD_W-1:0]  result,
    output logic                do_jump,
    output logic [`WORD_W-1:0]  j_addr,
    output logic                stall
);
    localparam int MSB = `WORD_W - 1;

    logic [MSB:0]           op2;
    logic [MSB:0]           alu_out;
    logic                   alu_cf;
    logic                   alu_sf;
    logic                   alu_of;
    logic                   is_lui;
    logic                   is_def;
    logic                   is_set_op;
    logic                   set_unsigned;
    logic                   set_bit;
    logic                   is_shift;
    logic [`SHAMT_W-1:0]    shift_amt;
    logic [MSB:0]           shift_out;
    logic                   take_branch;
    logic                   is_mul;
    logic                   mul_start;
    logic                   mul_busy;
    logic                   busy_q;
    logic                   mul_done;
    logic [2*`WORD_W-1:0]   mul_product;
    logic [MSB:0]           mul_half;
    logic [MSB:0]           jump_target;
    logic [MSB:0]           branch_target;

    assign op2    = exe.alu_src ? exe.immd : reg2;
    assign is_lui = exe.opcode == isa_pkg::OP_LUI;

    // ALU with flags
    always_comb begin
        alu_out = '0;
        alu_cf  = 1'b0;
        alu_sf  = 1'b0;
        alu_of  = 1'b0;
        case (exe.alu_op)
            exec_pkg::ALU_ADD, exec_pkg::ALU_ADDU: begin
                {alu_cf, alu_out} = {1'b0, reg1} + {1'b0, op2};
                alu_sf = alu_out[MSB];
                alu_of = (reg1[MSB] == op2[MSB]) && (alu_out[MSB] != reg1[MSB]);
            end
            exec_pkg::ALU_SUB, exec_pkg::ALU_SUBU: begin
                // carry set means no borrow
                {alu_cf, alu_out} = {1'b0, reg1} + {1'b0, ~op2} + {{`WORD_W{1'b0}}, 1'b1};
                alu_sf = alu_out[MSB];
                alu_of = (reg1[MSB] != op2[MSB]) && (alu_out[MSB] != reg1[MSB]);
            end
            exec_pkg::ALU_AND:     alu_out = reg1 & op2;
            exec_pkg::ALU_OR:      alu_out = reg1 | op2;
            exec_pkg::ALU_XOR:     alu_out = reg1 ^ op2;
            exec_pkg::ALU_NOR_LUI: alu_out = is_lui ? {exe.immd[15:0], 16'b0} : ~(reg1 | op2);
            default:               alu_out = '0;
        endcase
    end

    assign is_def = exe.is_load_store
        || exe.opcode inside {isa_pkg::OP_ADDI, isa_pkg::OP_ADDIU, isa_pkg::OP_ANDI,
                              isa_pkg::OP_ORI, isa_pkg::OP_XORI, isa_pkg::OP_LUI}
        || (exe.r_op && exe.func inside {isa_pkg::FN_ADD, isa_pkg::FN_ADDU, isa_pkg::FN_SUB,
                                         isa_pkg::FN_SUBU, isa_pkg::FN_AND, isa_pkg::FN_OR,
                                         isa_pkg::FN_XOR, isa_pkg::FN_NOR});

    // set checker reads the subtract flags
    assign is_set_op = exe.opcode inside {isa_pkg::OP_SLTI, isa_pkg::OP_SLTIU}
        || (exe.r_op && exe.func inside {isa_pkg::FN_SLT, isa_pkg::FN_SLTU});
    assign set_unsigned = exe.opcode == isa_pkg::OP_SLTIU
        || (exe.r_op && exe.func == isa_pkg::FN_SLTU);
    assign set_bit = set_unsigned ? !alu_cf : (alu_of ^ alu_sf);

    // shifter, variable forms take the amount from rs
    assign is_shift = exe.r_op && exe.func inside {isa_pkg::FN_SLL, isa_pkg::FN_SRL,
        isa_pkg::FN_SRA, isa_pkg::FN_SLLV, isa_pkg::FN_SRLV, isa_pkg::FN_SRAV};
    assign shift_amt = exe.func inside {isa_pkg::FN_SLLV, isa_pkg::FN_SRLV, isa_pkg::FN_SRAV}
                     ? reg1[`SHAMT_W-1:0] : exe.shamt;

    always_comb begin
        case (exe.func)
            isa_pkg::FN_SLL, isa_pkg::FN_SLLV: shift_out = reg2 << shift_amt;
            isa_pkg::FN_SRL, isa_pkg::FN_SRLV: shift_out = reg2 >> shift_amt;
            isa_pkg::FN_SRA, isa_pkg::FN_SRAV: shift_out = $signed(reg2) >>> shift_amt;
            default:                           shift_out = '0;
        endcase
    end

    // multiplier, done is the cycle after busy drops
    assign is_mul    = exe.r_op && exe.func inside {isa_pkg::FN_MULT, isa_pkg::FN_MULTU};
    assign mul_done  = busy_q && !mul_busy;
    assign mul_start = is_mul && !mul_busy && !busy_q;
    assign stall     = is_mul && !mul_done;

    always_ff @(posedge sys_clk) begin
        if (!rst_n)
            busy_q <= 1'b0;
        else
            busy_q <= mul_busy;
    end

    seq_multiplier u_mul (
        .sys_clk   (sys_clk),
        .rst_n     (rst_n),
        .start     (mul_start),
        .is_signed (exe.func == isa_pkg::FN_MULT),
        .a         (reg1),
        .b         (reg2),
        .busy      (mul_busy),
        .product   (mul_product)
    );

    // shamt 2 low word, 3 high word
    assign mul_half = (exe.shamt == `SHAMT_W'(2)) ? mul_product[MSB:0]
                                                  : mul_product[2*`WORD_W-1:`WORD_W];

    always_comb begin
        if (is_set_op)
            result = {{MSB{1'b0}}, set_bit};
        else if (is_mul)
            result = mul_half;
        else if (is_def)
            result = alu_out;
        else if (is_shift)
            result = shift_out;
        else if (exe.is_jal)
            result = next_pc + `WORD_W'(4);   // link address
        else
            result = '0;
    end

    // branch comparator
    always_comb begin
        case (exe.opcode)
            isa_pkg::OP_BEQ:  take_branch = reg1 == reg2;
            isa_pkg::OP_BNE:  take_branch = reg1 != reg2;
            isa_pkg::OP_BLEZ: take_branch = reg1 == '0 || reg1[MSB];
            isa_pkg::OP_BGEZ: take_branch = !reg1[MSB];
            default:          take_branch = 1'b0;
        endcase
    end

    assign jump_target   = {next_pc[MSB:MSB-3], exe.j_index, 2'b00};
    assign branch_target = next_pc + {exe.immd[MSB-2:0], 2'b00};

    always_comb begin
        if (exe.is_jump) begin
            do_jump = 1'b1;
            j_addr  = exe.is_jr ? reg1 : jump_target;
        end else if (exe.is_branch && take_branch) begin
            do_jump = 1'b1;
            j_addr  = branch_target;
        end else begin
            do_jump = 1'b0;
            j_addr  = '0;
        end
    end

    // region and branch targets stay aligned as long as the fetch side supplies an aligned pc
    a_target_aligned: assert property (@(posedge sys_clk) disable iff (!rst_n)
        (do_jump && !exe.is_jr) |-> (j_addr[1:0] == 2'b00));

endmodule

`default_nettype wire

/* src/seq_multiplier.sv */
`timescale 1ns/1ps
`include "core_defs.svh"
`default_nettype none

module seq_multiplier (
    input  wire                     sys_clk,
    input  wire                     rst_n,
    input  wire                     start,
    input  wire                     is_signed,
    input  wire  [`WORD_W-1:0]      a,
    input  wire  [`WORD_W-1:0]      b,
    output logic                    busy,
    output logic [2*`WORD_W-1:0]    product
);
    localparam int MSB   = `WORD_W - 1;
    localparam int CNT_W = $clog2(`MUL_ITERS);

    exec_pkg::mul_state_e   state_q;
    logic [CNT_W-1:0]       count_q;
    logic [MSB:0]           mcand_q;    // |a|
    logic [2*`WORD_W-1:0]   acc_q;      // partial sum on top, multiplier bits below
    logic                   neg_q;
    logic [`WORD_W:0]       step_sum;
    logic [MSB:0]           mag_a;
    logic [MSB:0]           mag_b;

    assign mag_a = (is_signed && a[MSB]) ? -a : a;
    assign mag_b = (is_signed && b[MSB]) ? -b : b;

    // add multiplicand when the current multiplier bit is set
    assign step_sum = {1'b0, acc_q[2*`WORD_W-1:`WORD_W]} + (acc_q[0] ? {1'b0, mcand_q} : '0);

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            state_q <= exec_pkg::MUL_IDLE;
            count_q <= '0;
        end else begin
            case (state_q)
                exec_pkg::MUL_IDLE: begin
                    if (start) begin
                        state_q <= exec_pkg::MUL_RUN;
                        count_q <= '0;
                    end
                end
                exec_pkg::MUL_RUN: begin
                    count_q <= count_q + 1'b1;
                    if (count_q == CNT_W'(`MUL_ITERS - 1))
                        state_q <= exec_pkg::MUL_DONE;
                end
                exec_pkg::MUL_DONE: state_q <= exec_pkg::MUL_IDLE;
                default:            state_q <= exec_pkg::MUL_IDLE;
            endcase
        end
    end

    always_ff @(posedge sys_clk) begin
        if (state_q == exec_pkg::MUL_IDLE && start) begin
            mcand_q <= mag_a;
            acc_q   <= {{`WORD_W{1'b0}}, mag_b};
            neg_q   <= is_signed && (a[MSB] ^ b[MSB]);
        end else if (state_q == exec_pkg::MUL_RUN) begin
            acc_q <= {step_sum, acc_q[MSB:1]};  // shift right one bit per cycle
        end
    end

    assign busy    = state_q == exec_pkg::MUL_RUN;
    assign product = neg_q ? -acc_q : acc_q;     // held until the next start

    // the execute unit must hold off a new start until the run is over
    a_no_start_busy: assert property (@(posedge sys_clk) disable iff (!rst_n)
        !(start && busy));

endmodule

`default_nettype wire

/* src/instr_decoder.sv */
`timescale 1ns/1ps
`include "core_defs.svh"
`default_nettype none

module instr_decoder (
    input  wire [`WORD_W-1:0]   instr,
    dec_exe_if.dec              dec
);
    isa_pkg::opcode_e   opcode;
    isa_pkg::funct_e    func;
    logic [15:0]        imm16;
    logic               r_op;
    logic               zero_ext;
    logic               ld_st;

    assign opcode = isa_pkg::opcode_e'(instr[31:26]);
    assign func   = isa_pkg::funct_e'(instr[5:0]);
    assign imm16  = instr[15:0];
    assign r_op   = opcode == isa_pkg::OP_RTYPE;
    assign ld_st  = opcode inside {isa_pkg::OP_LW, isa_pkg::OP_SW};

    // logical immediates are zero extended
    assign zero_ext = opcode inside {isa_pkg::OP_ANDI, isa_pkg::OP_ORI, isa_pkg::OP_XORI};

    assign dec.opcode  = opcode;
    assign dec.func    = func;
    assign dec.shamt   = instr[10:6];
    assign dec.r_op    = r_op;
    assign dec.j_index = instr[25:0];
    assign dec.immd    = zero_ext ? {{(`WORD_W-16){1'b0}}, imm16}
                                  : {{(`WORD_W-16){imm16[15]}}, imm16};

    assign dec.alu_src = ld_st || opcode inside {
        isa_pkg::OP_ADDI, isa_pkg::OP_ADDIU, isa_pkg::OP_SLTI, isa_pkg::OP_SLTIU,
        isa_pkg::OP_ANDI, isa_pkg::OP_ORI, isa_pkg::OP_XORI, isa_pkg::OP_LUI};

    always_comb begin
        if (ld_st)
            dec.alu_op = exec_pkg::ALU_ADDU;                // address calc, no overflow
        else if (r_op)
            dec.alu_op = exec_pkg::alu_op_e'(instr[2:0]);
        else
            dec.alu_op = exec_pkg::alu_op_e'(instr[28:26]); // I-type class in opcode[2:0]
    end

    assign dec.is_jr     = r_op && func inside {isa_pkg::FN_JR, isa_pkg::FN_JALR};
    assign dec.is_jal    = opcode == isa_pkg::OP_JAL || (r_op && func == isa_pkg::FN_JALR);
    assign dec.is_jump   = opcode inside {isa_pkg::OP_J, isa_pkg::OP_JAL} || dec.is_jr;
    assign dec.is_branch = opcode inside {
        isa_pkg::OP_BEQ, isa_pkg::OP_BNE, isa_pkg::OP_BLEZ, isa_pkg::OP_BGEZ};
    assign dec.is_load_store = ld_st;

    // the jump mux in the execute unit gives jumps priority, both set would hide a branch
    always_comb begin
        if (!$isunknown(instr))
            a_jump_xor_branch: assert (!(dec.is_jump && dec.is_branch));
    end

endmodule

`default_nettype wire

/* src/dec_exe_if.sv */
`timescale 1ns/1ps
`include "core_defs.svh"
`default_nettype none

interface dec_exe_if;
    isa_pkg::opcode_e       opcode;
    isa_pkg::funct_e        func;
    logic [`SHAMT_W-1:0]    shamt;
    logic                   r_op;
    logic [25:0]            j_index;
    logic [`WORD_W-1:0]     immd;       // sign or zero extended
    logic                   alu_src;    // 1 selects immd as op2
    exec_pkg::alu_op_e      alu_op;
    logic                   is_jump;    // j, jal, jr, jalr
    logic                   is_branch;
    logic                   is_jal;     // jal, jalr
    logic                   is_jr;      // jr, jalr
    logic                   is_load_store;

    modport dec (
        output opcode, func, shamt, r_op, j_index, immd, alu_src, alu_op,
        output is_jump, is_branch, is_jal, is_jr, is_load_store
    );

    modport exe (
        input opcode, func, shamt, r_op, j_index, immd, alu_src, alu_op,
        input is_jump, is_branch, is_jal, is_jr, is_load_store
    );
endinterface

`default_nettype wire

/* src/exec_pkg.sv */
`default_nettype none

package exec_pkg;

    // matches func[2:0] / opcode[2:0] of the ALU instructions
    typedef enum logic [2:0] {
        ALU_ADD     = 3'b000,
        ALU_ADDU    = 3'b001,
        ALU_SUB     = 3'b010,
        ALU_SUBU    = 3'b011,
        ALU_AND     = 3'b100,
        ALU_OR      = 3'b101,
        ALU_XOR     = 3'b110,
        ALU_NOR_LUI = 3'b111   // lui when opcode says so
    } alu_op_e;

    typedef enum logic [1:0] {
        MUL_IDLE = 2'b00,
        MUL_RUN  = 2'b01,
        MUL_DONE = 2'b10
    } mul_state_e;

endpackage

`default_nettype wire

/* src/isa_pkg.sv */
`default_nettype none

package isa_pkg;

    // primary opcode, instr[31:26]
    typedef enum logic [5:0] {
        OP_RTYPE = 6'b000000,
        OP_J     = 6'b000010,
        OP_JAL   = 6'b000011,
        OP_BEQ   = 6'b000100,
        OP_BNE   = 6'b000101,
        OP_BLEZ  = 6'b000110,
        OP_BGEZ  = 6'b000111,  // low two bits pick the compare
        OP_ADDI  = 6'b001000,
        OP_ADDIU = 6'b001001,
        OP_SLTI  = 6'b001010,
        OP_SLTIU = 6'b001011,
        OP_ANDI  = 6'b001100,
        OP_ORI   = 6'b001101,
        OP_XORI  = 6'b001110,
        OP_LUI   = 6'b001111,
        OP_LW    = 6'b100011,
        OP_SW    = 6'b101011
    } opcode_e;

    // R-type function code, instr[5:0]
    typedef enum logic [5:0] {
        FN_SLL   = 6'b000000,
        FN_SRL   = 6'b000010,
        FN_SRA   = 6'b000011,
        FN_SLLV  = 6'b000100,
        FN_SRLV  = 6'b000110,
        FN_SRAV  = 6'b000111,
        FN_JR    = 6'b001000,
        FN_JALR  = 6'b001001,
        FN_MULT  = 6'b011000,
        FN_MULTU = 6'b011001,
        FN_ADD   = 6'b100000,
        FN_ADDU  = 6'b100001,
        FN_SUB   = 6'b100010,
        FN_SUBU  = 6'b100011,
        FN_AND   = 6'b100100,
        FN_OR    = 6'b100101,
        FN_XOR   = 6'b100110,
        FN_NOR   = 6'b100111,
        FN_SLT   = 6'b101010,
        FN_SLTU  = 6'b101011
    } funct_e;

endpackage

`default_nettype wire

/* src/core_defs.svh */
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// datapath and address width
`define WORD_W      32

// shift amount field, also used for the mult low/high select
`define SHAMT_W     5

// one multiplier bit per cycle
`define MUL_ITERS   32

`endif
